//--- verilog.f
common/cvtPkg.sv
lzc/lzCount8.sv
lzc/lzCount64.sv
source/cvtDecode.sv
source/cvtExecute.sv
source/cvtResult.sv
source/intToFloatUnit.sv
dv/tbClock.sv
dv/intToFloatUnit_chk.sv
dv/intToFloatUnitTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = intToFloatUnitTb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log
RUNARGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/intToFloatUnitTb.sv
`timescale 1ns/1ps

module intToFloatUnitTb;

	import cvtPkg::*;

	localparam int resetCycles		= 5;
	localparam int exactItems		= 86;
	localparam int roundItems		= 32;
	localparam int extremeItems		= 4;
	localparam int countItems		= 97;
	localparam int reservedItems	= 8;
	localparam int randomItems		= 500;
	localparam int maxGap			= 3;
	localparam int numTests			= 6;
	// Every item, the longest gaps, a drain per test, then slack
	localparam int watchdogCycles	= resetCycles + exactItems + roundItems + extremeItems
		+ countItems + reservedItems + randomItems * (1 + maxGap) + numTests * 6 + 20;

	logic		clock;
	logic		rstN;
	logic		inValid;
	cvtOp_e		inOp;
	word_t		inData;
	logic		outValid;
	word_t		outData;
	logic		outInexact;
	logic		outInvalid;

	logic [1:0]	pendOp [$];			// Items in flight, oldest first
	word_t		pendData [$];
	int			pendCycle [$];		// Edge that accepted the item
	int			cycleNum = 0;
	int			errorCount = 0;
	int			checkCount = 0;
	int			testErrors;
	int			testChecks;
	word_t		roundCases [8];

	tbClock #(.periodNs(100), .resetCycles(resetCycles)) clockGen (
		.clock	(clock),
		.rstN	(rstN)
	);

	intToFloatUnit dut0 (
		.clock		(clock),
		.rstN		(rstN),
		.inValid	(inValid),
		.inOp		(inOp),
		.inData		(inData),
		.outValid	(outValid),
		.outData	(outData),
		.outInexact	(outInexact),
		.outInvalid	(outInvalid)
	);

	always @(posedge clock) cycleNum <= cycleNum + 1;

	//////////////////////////////////////////////////
	// Reference model, returns {invalid, inexact, data}

	function automatic logic [65:0] expectedResult(input logic [1:0] op, input word_t data);
		logic			neg;
		word_t			mag;
		word_t			probe;
		word_t			kept;
		word_t			rem;
		word_t			half;
		int				top;
		int				shift;
		logic [10:0]	expo;
		logic			inexact;
		if (op == 2'd3)
			return {1'b1, 1'b0, 64'd0};
		neg = (op == opCvtSigned) && data[63];
		mag = neg ? 64'd0 - data : data;
		top = -1;							// Position of the leading one
		probe = mag;
		while (probe != 64'd0) begin
			top++;
			probe = probe >> 1;
		end
		if (op == opCountZeros)
			return {2'b00, (top < 0) ? 64'd64 : 64'(63 - top)};
		if (top < 0)
			return 66'd0;
		expo = 11'(1023 + top);
		inexact = 1'b0;
		if (top <= 52) begin
			kept = mag << (52 - top);		// Fits in the significand
		end else begin
			shift = top - 52;
			kept = mag >> shift;
			rem = mag & ((64'd1 << shift) - 64'd1);
			half = 64'd1 << (shift - 1);
			inexact = (rem != 64'd0);
			if (rem > half || (rem == half && kept[0]))
				kept = kept + 64'd1;
			if (kept[53]) begin				// Rounded up to the next power of two
				kept = kept >> 1;
				expo = expo + 11'd1;
			end
		end
		return {1'b0, inexact, neg, expo, kept[51:0]};
	endfunction

	function automatic word_t randomWord();
		return {$urandom(), $urandom()};
	endfunction

	task automatic checkValue(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			$display("** Error: %s got 0x%h expected 0x%h", name, got, expected);
			errorCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// Driving, one item per call

	task automatic sendItem(input cvtOp_e op, input word_t data);
		inValid = 1'b1;
		inOp = op;
		inData = data;
		pendOp.push_back(op);
		pendData.push_back(data);
		pendCycle.push_back(cycleNum + 1);
		@(posedge clock);
		#1;
		inValid = 1'b0;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic beginTest();
		testErrors = errorCount;
		testChecks = checkCount;
	endtask

	task automatic endTest(input string name);
		while (pendData.size() != 0) begin
			@(posedge clock);
			#1;
		end
		$display("%s: %0d results, %0d errors", name, checkCount - testChecks,
			errorCount - testErrors);
	endtask

	//////////////////////////////////////////////////
	// Compare each result half a cycle after it appears

	always @(negedge clock) begin : compareResults
		logic [1:0]		op;
		word_t			data;
		int				accepted;
		logic [65:0]	expected;
		if (rstN && outValid) begin
			if (pendData.size() == 0) begin
				$display("Result arrived with no item in flight at cycle %0d", cycleNum);
				errorCount++;
			end else begin
				op = pendOp.pop_front();
				data = pendData.pop_front();
				accepted = pendCycle.pop_front();
				expected = expectedResult(op, data);
				checkValue("outData", outData, expected[63:0]);
				checkValue("outInexact", 64'(outInexact), 64'(expected[64]));
				checkValue("outInvalid", 64'(outInvalid), 64'(expected[65]));
				// Counted at the next rising edge, like the bound assertion
				checkValue("latency", 64'(cycleNum + 1 - accepted), 64'd3);
				checkCount++;
			end
		end
	end

	initial begin : watchdog
		repeat (watchdogCycles) @(posedge clock);
		$display("Timeout: not all results arrived within %0d cycles", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin : mainSequence
		int			seedValue;
		int			total;
		logic [1:0]	opBits;
		word_t		data;
		inValid = 1'b0;
		inOp = opCvtSigned;
		inData = '0;
		seedValue = $urandom(32'hbecb);
		roundCases[0] = (64'd1 << 53) + 64'd1;			// Tie, even lsb stays
		roundCases[1] = (64'd1 << 53) + 64'd3;			// Tie, odd lsb rounds up
		roundCases[2] = (64'd1 << 62) + (64'd1 << 9);
		roundCases[3] = (64'd1 << 62) + (64'd3 << 9);
		roundCases[4] = (64'd1 << 62) + (64'd1 << 9) + 64'd1;
		roundCases[5] = (64'd1 << 54) - 64'd1;			// All ones carry
		roundCases[6] = 64'hFFFF_FFFF_FFFF_FC00;
		roundCases[7] = 64'h7FFF_FFFF_FFFF_FE00;
		wait (rstN === 1'b1);
		@(posedge clock);
		#1;

		beginTest();
		sendItem(opCvtSigned, 64'd0);
		sendItem(opCvtUnsigned, 64'd0);
		sendItem(opCvtSigned, 64'd1);
		sendItem(opCvtUnsigned, 64'd1);
		for (int k = 0; k < 64; k++) begin
			sendItem(opCvtUnsigned, 64'd1 << k);
		end
		for (int k = 1; k <= 16; k++) begin
			sendItem(opCvtSigned, 64'd0 - 64'(k));
		end
		sendItem(opCvtSigned, (64'd1 << 53) - 64'd1);
		sendItem(opCvtUnsigned, (64'd1 << 53) - 64'd1);
		endTest("Exact conversions");

		beginTest();
		for (int i = 0; i < 8; i++) begin
			sendItem(opCvtUnsigned, roundCases[i]);
		end
		for (int i = 0; i < 4; i++) begin
			sendItem(opCvtSigned, 64'd0 - roundCases[i]);
		end
		for (int i = 0; i < 20; i++) begin
			data = randomWord() | (64'd1 << $urandom_range(54, 63));
			sendItem((i % 2 == 0) ? opCvtSigned : opCvtUnsigned, data);
		end
		endTest("Rounding");

		beginTest();
		sendItem(opCvtSigned, 64'h8000_0000_0000_0000);
		sendItem(opCvtUnsigned, 64'hFFFF_FFFF_FFFF_FFFF);
		sendItem(opCvtSigned, 64'hFFFF_FFFF_FFFF_FFFF);
		sendItem(opCvtSigned, 64'h7FFF_FFFF_FFFF_FFFF);
		endTest("Extremes");

		beginTest();
		for (int k = 0; k < 64; k++) begin
			sendItem(opCountZeros, 64'd1 << k);
		end
		for (int i = 0; i < 32; i++) begin
			sendItem(opCountZeros, randomWord() >> $urandom_range(0, 63));
		end
		sendItem(opCountZeros, 64'd0);
		endTest("Leading-zero count");

		beginTest();
		for (int i = 0; i < 4; i++) begin
			sendItem(cvtOp_e'(2'd3), randomWord());
			sendItem(cvtOp_e'(2'(i % 3)), randomWord());	// Must come out clean
		end
		endTest("Reserved opcode");

		beginTest();
		for (int i = 0; i < randomItems; i++) begin
			opBits = 2'($urandom_range(0, 3));
			sendItem(cvtOp_e'(opBits), randomWord() >> $urandom_range(0, 63));
			if ($urandom_range(0, 3) == 0)
				idleCycles($urandom_range(1, maxGap));
		end
		endTest("Random throughput");

		total = errorCount + dut0.chk0.failCount;
		$display("Done: %0d results checked, %0d errors, %0d assertion failures",
			checkCount, errorCount, dut0.chk0.failCount);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/intToFloatUnit_chk.sv
`timescale 1ns/1ps

module intToFloatUnit_chk (
	input	logic	clock,
	input	logic	rstN,
	input	logic	inValid,
	input	logic	outValid,
	input	logic	outInexact,
	input	logic	outInvalid
);

	int		failCount = 0;		// Failed assertions so far

	// Result register clears with the rest of the pipeline
	validLowAfterReset: assert property (@(posedge clock) !rstN |=> !outValid)
	else begin
		$error("outValid high in the cycle after reset");
		failCount++;
	end

	// Three registers between input and output
	validThreeCycles: assert property (
		@(posedge clock) disable iff (!rstN) inValid |-> ##3 outValid)
	else begin
		$error("outValid missing three cycles after inValid");
		failCount++;
	end

	// A reserved opcode never reaches the rounding logic
	flagsExclusive: assert property (
		@(posedge clock) disable iff (!rstN) !(outInvalid && outInexact))
	else begin
		$error("outInvalid and outInexact set together");
		failCount++;
	end

endmodule

bind intToFloatUnit intToFloatUnit_chk chk0 (
	.clock		(clock),
	.rstN		(rstN),
	.inValid	(inValid),
	.outValid	(outValid),
	.outInexact	(outInexact),
	.outInvalid	(outInvalid)
);

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs		= 100,
	parameter int resetCycles	= 5
) (
	output	logic	clock,
	output	logic	rstN
);

	initial begin
		clock = 1'b0;
		forever #(periodNs / 2) clock = ~clock;
	end

	// Release just after an edge so the DUT sees a clean level
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clock);
		#1;
		rstN = 1'b1;
	end

endmodule

//--- source/intToFloatUnit.sv
`timescale 1ns/1ps

module intToFloatUnit (
	input	logic				clock,
	input	logic				rstN,
	input	logic				inValid,
	input	cvtPkg::cvtOp_e		inOp,
	input	cvtPkg::word_t		inData,
	output	logic				outValid,
	output	cvtPkg::word_t		outData,
	output	logic				outInexact,
	output	logic				outInvalid
);

	import cvtPkg::*;

	//////////////////////////////////////////////////
	// Decode to execute

	logic		decValid;
	cvtOp_e		decOp;
	logic		decSign;
	word_t		decMag;
	logic		decBadOp;

	//////////////////////////////////////////////////
	// Execute to result

	logic		exeValid;
	cvtOp_e		exeOp;
	logic		exeSign;
	logic		exeBadOp;
	logic		exeZero;
	lzNum_t		exeLz;
	word_t		exeNorm;

	cvtDecode decode0 (
		.clock		(clock),
		.rstN		(rstN),
		.inValid	(inValid),
		.inOp		(inOp),
		.inData		(inData),
		.decValid	(decValid),
		.decOp		(decOp),
		.decSign	(decSign),
		.decMag		(decMag),
		.decBadOp	(decBadOp)
	);

	cvtExecute execute0 (
		.clock		(clock),
		.rstN		(rstN),
		.decValid	(decValid),
		.decOp		(decOp),
		.decSign	(decSign),
		.decMag		(decMag),
		.decBadOp	(decBadOp),
		.exeValid	(exeValid),
		.exeOp		(exeOp),
		.exeSign	(exeSign),
		.exeBadOp	(exeBadOp),
		.exeZero	(exeZero),
		.exeLz		(exeLz),
		.exeNorm	(exeNorm)
	);

	cvtResult result0 (
		.clock		(clock),
		.rstN		(rstN),
		.exeValid	(exeValid),
		.exeOp		(exeOp),
		.exeSign	(exeSign),
		.exeBadOp	(exeBadOp),
		.exeZero	(exeZero),
		.exeLz		(exeLz),
		.exeNorm	(exeNorm),
		.outValid	(outValid),
		.outData	(outData),
		.outInexact	(outInexact),
		.outInvalid	(outInvalid)
	);

endmodule

//--- source/cvtResult.sv
`timescale 1ns/1ps

module cvtResult (
	input	logic				clock,
	input	logic				rstN,
	input	logic				exeValid,
	input	cvtPkg::cvtOp_e		exeOp,
	input	logic				exeSign,
	input	logic				exeBadOp,
	input	logic				exeZero,
	input	cvtPkg::lzNum_t		exeLz,
	input	cvtPkg::word_t		exeNorm,
	output	logic				outValid,
	output	cvtPkg::word_t		outData,
	output	logic				outInexact,
	output	logic				outInvalid
);

	import cvtPkg::*;

	logic			lsb;
	logic			guard;
	logic			sticky;
	logic			roundUp;
	logic [53:0]	sigSum;			// 53-bit significand plus carry
	logic			carry;
	mant_t			mant;
	expo_t			expo;
	word_t			result;
	logic			inexact;

	//////////////////////////////////////////////////
	// Round to nearest even

	assign lsb		= exeNorm[11];
	assign guard	= exeNorm[10];
	assign sticky	= |exeNorm[9:0];

	// Tie goes up only when the kept lsb is odd
	assign roundUp	= guard && (sticky || lsb);
	assign sigSum	= {1'b0, exeNorm[63:11]} + {53'd0, roundUp};
	assign carry	= sigSum[53];

	// A carry leaves sigSum at exactly 2^53 and the fraction all zeros
	assign mant = sigSum[51:0];
	assign expo = expTop - {5'd0, exeLz} + {10'd0, carry};

	//////////////////////////////////////////////////
	// Result select

	always_comb begin
		result	= '0;
		inexact	= 1'b0;
		if (exeBadOp) begin
			result = '0;						// Reserved code
		end else if (exeOp == opCountZeros) begin
			result = exeZero ? 64'd64 : {58'd0, exeLz};
		end else if (exeZero) begin
			result = '0;						// Positive zero
		end else begin
			result	= {exeSign, expo, mant};
			inexact	= guard || sticky;
		end
	end

	//////////////////////////////////////////////////
	// Output register

	always_ff @(posedge clock) begin
		if (!rstN) begin
			outValid	<= 1'b0;
			outInexact	<= 1'b0;
			outInvalid	<= 1'b0;
		end else begin
			outValid	<= exeValid;
			if (exeValid) begin
				outInexact	<= inexact;
				outInvalid	<= exeBadOp;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (exeValid) begin
			outData <= result;
		end
	end

endmodule

//--- source/cvtExecute.sv
`timescale 1ns/1ps

module cvtExecute (
	input	logic				clock,
	input	logic				rstN,
	input	logic				decValid,
	input	cvtPkg::cvtOp_e		decOp,
	input	logic				decSign,
	input	cvtPkg::word_t		decMag,
	input	logic				decBadOp,
	output	logic				exeValid,
	output	cvtPkg::cvtOp_e		exeOp,
	output	logic				exeSign,
	output	logic				exeBadOp,
	output	logic				exeZero,
	output	cvtPkg::lzNum_t		exeLz,
	output	cvtPkg::word_t		exeNorm
);

	import cvtPkg::*;

	lzNum_t		lzNum;
	logic		nonZero;
	word_t		normMag;

	//////////////////////////////////////////////////
	// Leading-zero count

	lzCount64 lzWord (
		.data	(decMag),
		.num	(lzNum),
		.valid	(nonZero)
	);

	// Leading one lands on bit 63
	assign normMag = decMag << lzNum;

	//////////////////////////////////////////////////
	// Stage register

	always_ff @(posedge clock) begin
		if (!rstN) begin
			exeValid <= 1'b0;
		end else begin
			exeValid <= decValid;
		end
	end

	always_ff @(posedge clock) begin
		if (decValid) begin
			exeOp		<= decOp;			// Controls pass through
			exeSign		<= decSign;
			exeBadOp	<= decBadOp;
			exeZero		<= !nonZero;
			exeLz		<= lzNum;
			exeNorm		<= normMag;			// Zero word stays zero
		end
	end

endmodule

//--- source/cvtDecode.sv
`timescale 1ns/1ps

module cvtDecode (
	input	logic				clock,
	input	logic				rstN,
	input	logic				inValid,
	input	cvtPkg::cvtOp_e		inOp,
	input	cvtPkg::word_t		inData,
	output	logic				decValid,
	output	cvtPkg::cvtOp_e		decOp,
	output	logic				decSign,
	output	cvtPkg::word_t		decMag,
	output	logic				decBadOp
);

	import cvtPkg::*;

	logic		badOp;
	logic		sign;
	word_t		mag;

	//////////////////////////////////////////////////
	// Opcode check and sign split

	assign badOp = !(inOp inside {opCvtSigned, opCvtUnsigned, opCountZeros});

	// Only a signed conversion looks at bit 63
	assign sign = (inOp == opCvtSigned) && inData[63];

	// Negating the minimum value wraps back to 2^63, which is the right magnitude
	assign mag = sign ? (~inData + 64'd1) : inData;

	//////////////////////////////////////////////////
	// Stage register

	always_ff @(posedge clock) begin
		if (!rstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= inValid;
		end
	end

	// Payload only moves with a valid item
	always_ff @(posedge clock) begin
		if (inValid) begin
			decOp		<= inOp;
			decSign		<= sign;
			decMag		<= mag;
			decBadOp	<= badOp;
		end
	end

endmodule

//--- lzc/lzCount64.sv
`timescale 1ns/1ps

module lzCount64 (
	input	cvtPkg::word_t		data,
	output	cvtPkg::lzNum_t		num,
	output	logic				valid		// Low for a zero word
);

	logic [7:0]		byteValid;
	logic [2:0]		byteNum [8];

	//////////////////////////////////////////////////
	// One counter per byte, byte 0 is data[7:0]

	for (genvar i = 0; i < 8; i++) begin : genByte
		lzCount8 lzByte (
			.data	(data[8*i+7 -: 8]),
			.num	(byteNum[i]),
			.valid	(byteValid[i])
		);
	end

	assign valid = |byteValid;

	// Highest nonzero byte wins, its offset forms the upper three bits
	always_comb begin
		if (byteValid[7])
			num = {3'd0, byteNum[7]};
		else if (byteValid[6])
			num = {3'd1, byteNum[6]};
		else if (byteValid[5])
			num = {3'd2, byteNum[5]};
		else if (byteValid[4])
			num = {3'd3, byteNum[4]};
		else if (byteValid[3])
			num = {3'd4, byteNum[3]};
		else if (byteValid[2])
			num = {3'd5, byteNum[2]};
		else if (byteValid[1])
			num = {3'd6, byteNum[1]};
		else if (byteValid[0])
			num = {3'd7, byteNum[0]};
		else
			num = '0;
	end

endmodule

//--- lzc/lzCount8.sv
`timescale 1ns/1ps

module lzCount8 (
	input	logic [7:0]		data,
	output	logic [2:0]		num,		// Zeros above highest set bit
	output	logic			valid		// Byte holds a one
);

	// Priority encode from the top bit down
	always_comb begin
		casez (data)
			8'b1???????:	num = 3'd0;
			8'b01??????:	num = 3'd1;
			8'b001?????:	num = 3'd2;
			8'b0001????:	num = 3'd3;
			8'b00001???:	num = 3'd4;
			8'b000001??:	num = 3'd5;
			8'b0000001?:	num = 3'd6;
			8'b00000001:	num = 3'd7;
			default:		num = 3'd0;		// Zero byte, valid low
		endcase
	end

	assign valid = |data;

endmodule

//--- common/cvtPkg.sv
package cvtPkg;

	//////////////////////////////////////////////////
	// Data widths

	typedef logic [63:0]	word_t;		// Operand and result word
	typedef logic [5:0]		lzNum_t;	// Leading-zero position in a word
	typedef logic [10:0]	expo_t;		// Biased exponent
	typedef logic [51:0]	mant_t;		// Stored fraction

	//////////////////////////////////////////////////
	// Opcodes

	// Code 2'd3 is reserved and flagged invalid
	typedef enum logic [1:0] {
		opCvtSigned		= 2'd0,		// Signed int64 to double
		opCvtUnsigned	= 2'd1,		// Unsigned int64 to double
		opCountZeros	= 2'd2		// Plain leading-zero count
	} cvtOp_e;

	//////////////////////////////////////////////////
	// Double format

	localparam expo_t expBias	= 11'd1023;

	// Exponent when the leading one sits at bit 63
	localparam expo_t expTop	= expBias + 11'd63;

endpackage
